// ==== cycle_sequencer.sv ====
`timescale 1ns/1ps

module cycle_sequencer (
	input  logic                   phi0,
	input  logic                   reset,
	input  logic                   ready,
	input  decode_pkg::op_class_e  op_class,
	input  logic                   acr,
	input  logic                   branch_cond,
	output timing_pkg::t_state_e   t_state
);

	import timing_pkg::*;
	import decode_pkg::*;

	t_state_e state_q;
	t_state_e state_d;
	logic     acr_latch;	// Carry seen in TS_3
	logic     br_taken;	// Branch condition seen in TS_2

	// Carry and branch latches only move on completed cycles
	always_ff @(posedge phi0) begin
		if (reset) begin
			acr_latch <= 1'b0;
			br_taken  <= 1'b0;
		end else if (ready) begin
			if (state_q == TS_3) begin
				acr_latch <= acr;
			end
			if (state_q == TS_2) begin
				br_taken <= branch_cond;
			end
		end
	end

	// Next state
	always_comb begin
		state_d = TS_FETCH;
		case (state_q)
			TS_FETCH: begin
				state_d = TS_2;	// Opcode lands in ir on this edge
			end
			TS_2: begin
				case (op_class)
					CLS_IMPLIED,
					CLS_IMMEDIATE: begin
						state_d = TS_FETCH;	// Two-cycle path
					end
					CLS_BRANCH: begin
						state_d = branch_cond ? TS_3 : TS_FETCH;
					end
					default: begin
						state_d = TS_3;
					end
				endcase
			end
			TS_3: begin
				case (op_class)
					CLS_ABS_READ,
					CLS_ABSX_READ: begin
						state_d = TS_4;
					end
					CLS_ZP_RMW: begin
						state_d = TS_RMW_MODIFY;
					end
					CLS_BRANCH: begin
						// Taken branch needs PCH fix-up on page cross
						state_d = (br_taken && acr) ? TS_4 : TS_FETCH;
					end
					default: begin
						state_d = TS_FETCH;	// Zero-page read and store end here
					end
				endcase
			end
			TS_4: begin
				if ((op_class == CLS_ABSX_READ) && acr_latch) begin
					state_d = TS_5;	// Index carry into high byte
				end else begin
					state_d = TS_FETCH;
				end
			end
			TS_5: begin
				state_d = TS_FETCH;
			end
			TS_RMW_MODIFY: begin
				state_d = TS_RMW_WRITE;
			end
			TS_RMW_WRITE: begin
				state_d = TS_FETCH;
			end
			default: begin
				state_d = TS_FETCH;
			end
		endcase
	end

	always_ff @(posedge phi0) begin
		if (reset) begin
			state_q <= TS_FETCH;
		end else if (ready) begin
			state_q <= state_d;	// Hold the whole cycle while not ready
		end
	end

	assign t_state = state_q;

endmodule

// ==== decode_pkg.sv ====
`include "dispatch_settings.svh"

package decode_pkg;

	// Instruction classes seen by the timing logic
	typedef enum logic [2:0] {
		CLS_IMPLIED   = 3'd0,	// Also every unknown opcode
		CLS_IMMEDIATE = 3'd1,
		CLS_ZP_READ   = 3'd2,
		CLS_ZP_STORE  = 3'd3,
		CLS_ABS_READ  = 3'd4,
		CLS_ABSX_READ = 3'd5,
		CLS_ZP_RMW    = 3'd6,
		CLS_BRANCH    = 3'd7
	} op_class_e;

	// Opcodes known to the decode table
	typedef enum logic [`DISPATCH_DATA_WIDTH-1:0] {
		OP_NOP      = 8'hEA,
		OP_INX      = 8'hE8,
		OP_CLC      = 8'h18,
		OP_LDA_IMM  = 8'hA9,
		OP_ADC_IMM  = 8'h69,
		OP_LDA_ZP   = 8'hA5,
		OP_STA_ZP   = 8'h85,
		OP_LDA_ABS  = 8'hAD,
		OP_LDA_ABSX = 8'hBD,
		OP_INC_ZP   = 8'hE6,
		OP_ASL_ZP   = 8'h06,
		OP_BNE      = 8'hD0,
		OP_BEQ      = 8'hF0
	} opcode_e;

endpackage

// ==== decode_pla.sv ====
`timescale 1ns/1ps
`include "dispatch_settings.svh"

module decode_pla (
	input  logic [`DISPATCH_DATA_WIDTH-1:0] ir,
	output decode_pkg::op_class_e           op_class
);

	import decode_pkg::*;

	opcode_e opcode;

	assign opcode = opcode_e'(ir);

	always_comb begin
		case (opcode)
			OP_NOP,
			OP_INX,
			OP_CLC: begin
				op_class = CLS_IMPLIED;
			end
			OP_LDA_IMM,
			OP_ADC_IMM: begin
				op_class = CLS_IMMEDIATE;
			end
			OP_LDA_ZP: begin
				op_class = CLS_ZP_READ;
			end
			OP_STA_ZP: begin
				op_class = CLS_ZP_STORE;
			end
			OP_LDA_ABS: begin
				op_class = CLS_ABS_READ;
			end
			OP_LDA_ABSX: begin
				op_class = CLS_ABSX_READ;
			end
			OP_INC_ZP,
			OP_ASL_ZP: begin
				op_class = CLS_ZP_RMW;
			end
			OP_BNE,
			OP_BEQ: begin
				op_class = CLS_BRANCH;
			end
			default: begin
				op_class = CLS_IMPLIED;	// Unknown opcodes run as two-cycle implied
			end
		endcase
	end

endmodule

// ==== dispatch_settings.svh ====
`ifndef DISPATCH_SETTINGS_SVH
`define DISPATCH_SETTINGS_SVH

// Data bus and instruction register width
`define DISPATCH_DATA_WIDTH 8

// Opcode placed in ir by reset (NOP)
`define DISPATCH_RESET_OPCODE 8'hEA

`endif

// ==== dispatch_top.sv ====
`timescale 1ns/1ps
`include "dispatch_settings.svh"

module dispatch_top (
	input  logic                            phi0,
	input  logic                            reset,
	input  logic                            rdy,
	input  logic [`DISPATCH_DATA_WIDTH-1:0] data_in,
	input  logic                            acr,
	input  logic                            branch_cond,
	output logic                            sync,
	output logic                            wr,
	output logic                            ipc,
	output timing_pkg::t_state_e            t_state,
	output logic [`DISPATCH_DATA_WIDTH-1:0] ir
);

	import decode_pkg::*;

	op_class_e op_class;
	logic      ready;

	decode_pla u_decode_pla (
		.ir       (ir),
		.op_class (op_class)
	);

	ready_rw u_ready_rw (
		.rdy      (rdy),
		.t_state  (t_state),
		.op_class (op_class),
		.ready    (ready),
		.wr       (wr)
	);

	cycle_sequencer u_cycle_sequencer (
		.phi0        (phi0),
		.reset       (reset),
		.ready       (ready),
		.op_class    (op_class),
		.acr         (acr),
		.branch_cond (branch_cond),
		.t_state     (t_state)
	);

	pc_fetch_ctrl u_pc_fetch_ctrl (
		.phi0     (phi0),
		.reset    (reset),
		.ready    (ready),
		.t_state  (t_state),
		.op_class (op_class),
		.data_in  (data_in),
		.ir       (ir),
		.sync     (sync),
		.ipc      (ipc)
	);

endmodule

// ==== filelist.f ====
+incdir+.
decode_pkg.sv
timing_pkg.sv
decode_pla.sv
ready_rw.sv
cycle_sequencer.sv
pc_fetch_ctrl.sv
dispatch_top.sv
tb_dispatch.sv

// ==== pc_fetch_ctrl.sv ====
`timescale 1ns/1ps
`include "dispatch_settings.svh"

module pc_fetch_ctrl (
	input  logic                            phi0,
	input  logic                            reset,
	input  logic                            ready,
	input  timing_pkg::t_state_e            t_state,
	input  decode_pkg::op_class_e           op_class,
	input  logic [`DISPATCH_DATA_WIDTH-1:0] data_in,
	output logic [`DISPATCH_DATA_WIDTH-1:0] ir,
	output logic                            sync,
	output logic                            ipc
);

	import timing_pkg::*;
	import decode_pkg::*;

	logic fetch;
	logic ipc_operand;
	logic ipc_high;

	assign fetch = (t_state == TS_FETCH);

	// Instruction register loads on a completed fetch only
	always_ff @(posedge phi0) begin
		if (reset) begin
			ir <= `DISPATCH_RESET_OPCODE;
		end else if (ready && fetch) begin
			ir <= data_in;
		end
	end

	assign sync = fetch;

	// Second byte consumed by all but implied
	assign ipc_operand = (t_state == TS_2) && (op_class != CLS_IMPLIED);

	// Third byte for the absolute modes
	assign ipc_high = (t_state == TS_3) &&
		((op_class == CLS_ABS_READ) || (op_class == CLS_ABSX_READ));

	assign ipc = fetch || ipc_operand || ipc_high;

endmodule

// ==== ready_rw.sv ====
`timescale 1ns/1ps

module ready_rw (
	input  logic                   rdy,
	input  timing_pkg::t_state_e   t_state,
	input  decode_pkg::op_class_e  op_class,
	output logic                   ready,
	output logic                   wr
);

	import timing_pkg::*;
	import decode_pkg::*;

	logic store_cycle;
	logic rmw_cycle;

	// Store writes in its effective address cycle
	assign store_cycle = (t_state == TS_3) && (op_class == CLS_ZP_STORE);

	// RMW writes the old value then the new value
	assign rmw_cycle = ((t_state == TS_RMW_MODIFY) || (t_state == TS_RMW_WRITE)) &&
		(op_class == CLS_ZP_RMW);

	assign wr = store_cycle || rmw_cycle;

	// The 6502 never stalls a write cycle
	assign ready = rdy || wr;

endmodule

// ==== tb_dispatch.sv ====
`timescale 1ns/1ps
`include "dispatch_settings.svh"

module tb_dispatch;

	import decode_pkg::*;
	import timing_pkg::*;

	localparam int NUM_INSTR    = 400;
	localparam int SYNC_TIMEOUT = 50;

	typedef struct packed {
		logic [3:0] cycles;
		logic [3:0] writes;
		logic [3:0] incs;
	} inst_counts_t;

	logic                            phi0;
	logic                            reset;
	logic                            rdy;
	logic [`DISPATCH_DATA_WIDTH-1:0] data_in;
	logic                            acr;
	logic                            branch_cond;
	logic                            sync;
	logic                            wr;
	logic                            ipc;
	t_state_e                        t_state;
	logic [`DISPATCH_DATA_WIDTH-1:0] ir;

	logic [31:0] rng_state;
	int          error_count;
	int          write_stalls;	// Write cycles that ran with rdy low
	int          class_seen [8];

	// Instruction in flight
	logic [`DISPATCH_DATA_WIDTH-1:0] cur_opcode;
	op_class_e                       cur_class;
	logic                            in_flight;
	int                              cyc_cnt;
	int                              wr_cnt;
	int                              ipc_cnt;
	logic                            br_sampled;
	logic                            acr_sampled;
	logic [`DISPATCH_DATA_WIDTH-1:0] expected_ir;
	logic                            expect_sync;

	// Snapshot of the completed fetch cycle
	logic [`DISPATCH_DATA_WIDTH-1:0] fetch_opcode;
	logic                            fetch_wr;
	logic                            fetch_ipc;

	// Previous cycle for the stall checks
	logic                            prev_ready;
	t_state_e                        prev_t_state;
	logic                            prev_sync;
	logic [`DISPATCH_DATA_WIDTH-1:0] prev_ir;

	dispatch_top u_dut (
		.phi0        (phi0),
		.reset       (reset),
		.rdy         (rdy),
		.data_in     (data_in),
		.acr         (acr),
		.branch_cond (branch_cond),
		.sync        (sync),
		.wr          (wr),
		.ipc         (ipc),
		.t_state     (t_state),
		.ir          (ir)
	);

	initial begin
		phi0 = 1'b0;
		forever #2 phi0 = ~phi0;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic logic [7:0] pick_opcode();
		logic [31:0] r;
		r = next_rand();
		case (r[3:0])
			4'd0:    return OP_NOP;
			4'd1:    return OP_INX;
			4'd2:    return OP_CLC;
			4'd3:    return OP_LDA_IMM;
			4'd4:    return OP_ADC_IMM;
			4'd5:    return OP_LDA_ZP;
			4'd6:    return OP_STA_ZP;
			4'd7:    return OP_LDA_ABS;
			4'd8:    return OP_LDA_ABSX;
			4'd9:    return OP_INC_ZP;
			4'd10:   return OP_ASL_ZP;
			4'd11:   return OP_BNE;
			4'd12:   return OP_BEQ;
			default: return r[15:8];	// Mostly unknown opcodes
		endcase
	endfunction

	// Instruction classes by opcode
	function automatic op_class_e class_of(input logic [7:0] op);
		case (op)
			OP_LDA_IMM, OP_ADC_IMM: return CLS_IMMEDIATE;
			OP_LDA_ZP:              return CLS_ZP_READ;
			OP_STA_ZP:              return CLS_ZP_STORE;
			OP_LDA_ABS:             return CLS_ABS_READ;
			OP_LDA_ABSX:            return CLS_ABSX_READ;
			OP_INC_ZP, OP_ASL_ZP:   return CLS_ZP_RMW;
			OP_BNE, OP_BEQ:         return CLS_BRANCH;
			default:                return CLS_IMPLIED;
		endcase
	endfunction

	// Reference cycle model giving ready cycles, writes and PC increments per instruction
	function automatic inst_counts_t expected_counts(input op_class_e cls, input logic br,
		input logic carry);
		inst_counts_t e;
		e.writes = 4'd0;
		case (cls)
			CLS_IMMEDIATE: begin
				e.cycles = 4'd2;
				e.incs   = 4'd2;
			end
			CLS_ZP_READ: begin
				e.cycles = 4'd3;
				e.incs   = 4'd2;
			end
			CLS_ZP_STORE: begin
				e.cycles = 4'd3;
				e.writes = 4'd1;
				e.incs   = 4'd2;
			end
			CLS_ABS_READ: begin
				e.cycles = 4'd4;
				e.incs   = 4'd3;
			end
			CLS_ABSX_READ: begin
				e.cycles = carry ? 4'd5 : 4'd4;	// Index carry adds a fix-up cycle
				e.incs   = 4'd3;
			end
			CLS_ZP_RMW: begin
				e.cycles = 4'd5;
				e.writes = 4'd2;
				e.incs   = 4'd2;
			end
			CLS_BRANCH: begin
				if (!br) begin
					e.cycles = 4'd2;
				end else begin
					e.cycles = carry ? 4'd4 : 4'd3;
				end
				e.incs = 4'd2;
			end
			default: begin
				e.cycles = 4'd2;
				e.incs   = 4'd1;
			end
		endcase
		return e;
	endfunction

	task automatic stop_run();
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			error_count++;
			$display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic drive_inputs();
		logic [31:0] r;
		r = next_rand();
		rdy         = (r[1:0] != 2'b00);	// Low about a quarter of the time
		acr         = r[2];
		branch_cond = r[3];
		if (sync) begin
			data_in = pick_opcode();
		end else begin
			data_in = r[15:8];	// Operand byte
		end
	endtask

	// Inputs change shortly after each rising edge
	initial begin
		rng_state   = 32'h1d28a71d;
		rdy         = 1'b1;
		data_in     = OP_NOP;
		acr         = 1'b0;
		branch_cond = 1'b0;
		forever begin
			@(posedge phi0);
			#0.5;
			drive_inputs();
		end
	end

	// Samples one cycle at the falling edge
	task automatic sample_cycle(output logic fetch_done);
		logic         ready_now;
		inst_counts_t e;
		@(negedge phi0);
		ready_now = rdy || wr;
		if (!prev_ready) begin
			check_value("t_state during stall", t_state, prev_t_state);
			check_value("sync during stall", sync, prev_sync);
			check_value("ir during stall", ir, prev_ir);
		end
		check_value("sync", sync, expect_sync);
		if (expect_sync) begin
			check_value("t_state at sync", t_state, TS_FETCH);
		end
		check_value("ir", ir, expected_ir);
		fetch_done = 1'b0;
		if (ready_now && sync) begin
			fetch_done   = 1'b1;
			fetch_opcode = data_in;
			fetch_wr     = wr;
			fetch_ipc    = ipc;
		end else if (ready_now && in_flight) begin
			if (cyc_cnt == 1) begin
				br_sampled = branch_cond;	// TS_2
			end
			if (cyc_cnt == 2) begin
				acr_sampled = acr;	// TS_3
			end
			cyc_cnt++;
			wr_cnt  += wr;
			ipc_cnt += ipc;
			if (wr && !rdy) begin
				write_stalls++;
			end
			// Fetch follows once the reference length is reached
			e           = expected_counts(cur_class, br_sampled, acr_sampled);
			expect_sync = (cyc_cnt == e.cycles);
		end
		prev_ready   = ready_now;
		prev_t_state = t_state;
		prev_sync    = sync;
		prev_ir      = ir;
	endtask

	task automatic wait_ready_sync();
		logic fetch_done;
		int   waited;
		waited     = 0;
		fetch_done = 1'b0;
		while (!fetch_done) begin
			if (waited == SYNC_TIMEOUT) begin
				$display("Timeout: no completed fetch with sync high within %0d cycles",
					SYNC_TIMEOUT);
				stop_run();
			end
			sample_cycle(fetch_done);
			waited++;
		end
	endtask

	task automatic begin_instruction();
		cur_opcode  = fetch_opcode;
		cur_class   = class_of(fetch_opcode);
		expected_ir = fetch_opcode;	// ir loads at the end of the fetch
		expect_sync = 1'b0;
		cyc_cnt     = 1;
		wr_cnt      = fetch_wr;
		ipc_cnt     = fetch_ipc;
		br_sampled  = 1'b0;
		acr_sampled = 1'b0;
		in_flight   = 1'b1;
	endtask

	task automatic compare_instruction();
		inst_counts_t e;
		e = expected_counts(cur_class, br_sampled, acr_sampled);
		check_value($sformatf("ready cycles of opcode %02h", cur_opcode), cyc_cnt, e.cycles);
		check_value($sformatf("wr count of opcode %02h", cur_opcode), wr_cnt, e.writes);
		check_value($sformatf("ipc count of opcode %02h", cur_opcode), ipc_cnt, e.incs);
		class_seen[cur_class]++;
	endtask

	initial begin
		$timeformat(-9, 1, " ns", 8);
		reset        = 1'b1;
		error_count  = 0;
		write_stalls = 0;
		in_flight    = 1'b0;
		expected_ir  = `DISPATCH_RESET_OPCODE;
		expect_sync  = 1'b1;
		prev_ready   = 1'b1;
		prev_t_state = TS_FETCH;
		prev_sync    = 1'b1;
		prev_ir      = `DISPATCH_RESET_OPCODE;
		foreach (class_seen[i]) begin
			class_seen[i] = 0;
		end
		repeat (3) @(posedge phi0);
		#0.5;
		reset = 1'b0;

		// First cycle out of reset is a fetch
		#1;
		check_value("sync", sync, 1'b1);
		check_value("wr", wr, 1'b0);
		check_value("t_state", t_state, TS_FETCH);
		check_value("ir", ir, `DISPATCH_RESET_OPCODE);

		wait_ready_sync();
		begin_instruction();
		for (int n = 0; n < NUM_INSTR; n++) begin
			wait_ready_sync();
			compare_instruction();
			begin_instruction();
		end

		foreach (class_seen[i]) begin
			if (class_seen[i] == 0) begin
				$display("Instruction class %0d never ran", i);
				error_count++;
			end
		end
		if (write_stalls == 0) begin
			$display("No write cycle ran while rdy was low");
			error_count++;
		end

		if (error_count == 0) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			stop_run();
		end
	end

endmodule

// ==== timing_pkg.sv ====
package timing_pkg;

	// Timing states of one instruction; TS_FETCH doubles as T1 of the 6502
	typedef enum logic [2:0] {
		TS_FETCH      = 3'd0,	// Opcode fetch, sync high
		TS_2          = 3'd1,	// Second byte / two-cycle end
		TS_3          = 3'd2,
		TS_4          = 3'd3,
		TS_5          = 3'd4,	// Page cross fix-up for abs,X
		TS_RMW_MODIFY = 3'd5,	// Dummy write of old value
		TS_RMW_WRITE  = 3'd6	// Final write of new value
	} t_state_e;

endpackage
